//--- Makefile
# Verilator build and run of the cpu testbench
TOP = cpu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f cpu.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cpu.f
source/core_pkg.sv
source/fetch.sv
source/regfile.sv
source/hazard.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/cpu.sv
testbench/cpu_tb.sv

//--- source/core_pkg.sv
// Core widths, opcodes, instruction views, forwarding selects and stage structs
package core_pkg;

    localparam int WORD_W = 32;                     // Data path width
    localparam int REG_N  = 16;                     // Architectural registers
    localparam int IMM_W  = 20;                     // I view immediate width

    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [$clog2(REG_N)-1:0] reg_addr_t;

    // Code 0 and codes above OP_OUT are undefined and retire as no-ops
    typedef enum logic [3:0] {
        OP_ADD  = 4'h1,                             // rd = rs1 + rs2
        OP_SUB  = 4'h2,                             // rd = rs1 - rs2
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,                             // rd = rs1 + imm
        OP_LW   = 4'h7,                             // rd = mem[rs1 + imm]
        OP_SW   = 4'h8,                             // mem[rs1 + imm] = rd
        OP_BEQ  = 4'h9,                             // if rs1 == rd then pc += imm
        OP_OUT  = 4'hA                              // Post rd to the output port
    } op_t;

    typedef struct packed {
        op_t                     op;
        reg_addr_t               rd;                // Also second source of SW, BEQ, OUT
        reg_addr_t               rs1;
        reg_addr_t               rs2;
        logic [15:0]             unused;
    } r_inst_t;

    typedef struct packed {
        op_t                     op;
        reg_addr_t               rd;
        reg_addr_t               rs1;
        logic [IMM_W-1:0]        imm;               // Signed
    } i_inst_t;

    typedef union packed {
        r_inst_t r;                                 // Register form
        i_inst_t i;                                 // Immediate form
    } inst_t;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,                              // Register file, write-first
        FWD_EX = 2'd1,                              // Execute stage result
        FWD_MM = 2'd2                               // Memory stage result
    } fwd_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        inst_t     inst;
    } id_t;

    typedef struct packed {
        logic      valid;
        op_t       op;
        reg_addr_t rd;
        logic      rd_en;
        word_t     opa;                             // First ALU operand
        word_t     opb;                             // Second ALU operand or immediate
        word_t     sdata;                           // Store, compare or OUT value
        word_t     pc;
    } ex_t;

    typedef struct packed {
        logic      valid;
        op_t       op;
        reg_addr_t rd;
        logic      rd_en;
        word_t     result;                          // ALU value or data address
        word_t     sdata;
    } mm_t;

    typedef struct packed {
        logic      valid;
        logic      rd_en;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

//--- source/cpu.sv
// Core top level connecting fetch, decode, execute, memory, hazard and registers
`timescale 1ns/100ps

module cpu #(
    parameter int CODE_AW     = 8,
    parameter int DATA_AW     = 6,
    parameter int OUT_CREDITS = 4
) (
    input  logic                clk,
    input  logic                reset,
    output logic [CODE_AW-1:0]  code_addr,
    input  core_pkg::word_t     code_data,
    output logic                out_valid,
    output core_pkg::word_t     out_data,
    input  logic                out_credit
);
    import core_pkg::*;

    id_t       id_q;                                // Stage registers
    ex_t       ex_q;
    mm_t       mm_q;
    wb_t       wb_q;

    logic      stall;
    logic      flush;
    logic      bubble;                              // Load-use hole into ex
    logic      branch;
    word_t     target;
    fwd_t      rs1_sel;
    fwd_t      rs2_sel;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      uses_rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_data;
    word_t     mem_data;
    logic      ex_load;
    logic      out_busy;

    assign bubble = stall && !out_busy;             // Stall without a freeze is load-use

    hazard u_hazard (
        .rs1      (rs1_addr),
        .rs2      (rs2_addr),
        .uses_rs2 (uses_rs2),
        .ex_rd    (ex_q.rd),
        .ex_rd_en (ex_q.valid && ex_q.rd_en),
        .ex_load  (ex_load),
        .mm_rd    (mm_q.rd),
        .mm_rd_en (mm_q.valid && mm_q.rd_en),
        .out_busy (out_busy),
        .branch   (branch),
        .stall    (stall),
        .flush    (flush),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel)
    );

    fetch #(.CODE_AW(CODE_AW)) u_fetch (
        .clk, .reset, .stall, .flush, .branch, .target,
        .code_addr, .code_data,
        .down (id_q)
    );

    // Writeback is just the memory register driving the write port
    regfile u_regfile (
        .clk,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rd_en    (wb_q.valid && wb_q.rd_en),
        .rd_addr  (wb_q.rd),
        .rd_data  (wb_q.data)
    );

    decode u_decode (
        .clk, .reset, .stall,
        .flush    (flush || bubble),
        .up       (id_q),
        .rs1_sel, .rs2_sel, .alu_data, .mem_data, .rs1_data, .rs2_data,
        .rs1_addr, .rs2_addr, .uses_rs2,
        .down     (ex_q)
    );

    execute u_execute (
        .clk, .reset,
        .stall    (out_busy),                       // Load-use lets execute drain
        .flush,
        .up       (ex_q),
        .bypass   (alu_data),
        .load     (ex_load),
        .branch, .target,
        .down     (mm_q)
    );

    memory #(.DATA_AW(DATA_AW), .OUT_CREDITS(OUT_CREDITS)) u_memory (
        .clk, .reset,
        .up       (mm_q),
        .bypass   (mem_data),
        .out_busy, .out_valid, .out_data, .out_credit,
        .down     (wb_q)
    );

endmodule

//--- source/decode.sv
// Decode stage with field extraction, operand forwarding and ex output register
`timescale 1ns/100ps

module decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                flush,
    input  core_pkg::id_t       up,
    input  core_pkg::fwd_t      rs1_sel,
    input  core_pkg::fwd_t      rs2_sel,
    input  core_pkg::word_t     alu_data,
    input  core_pkg::word_t     mem_data,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    output logic                uses_rs2,
    output core_pkg::ex_t       down
);
    import core_pkg::*;

    inst_t inst;
    op_t   op;
    logic  is_r;                                    // R view, rs2 is a register
    logic  uses_rs1;
    logic  uses_st;                                 // Second source taken from rd field
    logic  rd_en;
    word_t imm;
    word_t src1;
    word_t src2;
    ex_t   next;

    function automatic word_t pick(fwd_t sel, word_t rf, word_t ex, word_t mm);
        case (sel)
            FWD_EX:  return ex;
            FWD_MM:  return mm;
            default: return rf;
        endcase
    endfunction

    assign inst = up.inst;
    assign op   = inst.r.op;                        // Same position in both views

    always_comb begin
        is_r     = 1'b0;
        uses_rs1 = 1'b0;
        uses_st  = 1'b0;
        rd_en    = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                is_r     = 1'b1;
                uses_rs1 = 1'b1;
                rd_en    = 1'b1;
            end
            OP_ADDI, OP_LW: begin
                uses_rs1 = 1'b1;
                rd_en    = 1'b1;
            end
            OP_SW, OP_BEQ: begin
                uses_rs1 = 1'b1;
                uses_st  = 1'b1;
            end
            OP_OUT: begin
                uses_st  = 1'b1;                    // Only the rd field is read
            end
            default: begin
            end                                     // Undefined, no-op
        endcase
    end

    assign rs1_addr = (up.valid && uses_rs1) ? inst.r.rs1 : '0;  // r0 never hazards
    assign rs2_addr = is_r ? inst.r.rs2 : inst.r.rd;
    assign uses_rs2 = up.valid && (is_r || uses_st);

    assign imm  = {{(WORD_W - IMM_W){inst.i.imm[IMM_W-1]}}, inst.i.imm};  // Sign extend
    assign src1 = pick(rs1_sel, rs1_data, alu_data, mem_data);
    assign src2 = pick(rs2_sel, rs2_data, alu_data, mem_data);

    always_comb begin
        next.valid = up.valid;
        next.op    = op;
        next.rd    = inst.r.rd;
        next.rd_en = rd_en;
        next.opa   = src1;
        next.opb   = is_r ? src2 : imm;             // Immediate for ADDI, LW, SW, BEQ
        next.sdata = src2;
        next.pc    = up.pc;
    end

    // Flush covers both the branch kill and the load-use bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            down.valid <= 1'b0;
        end else if (flush) begin
            down.valid <= 1'b0;
        end else if (!stall) begin
            down <= next;
        end
    end

endmodule

//--- source/execute.sv
// Execute stage with ALU, address generation, branch compare and mm register
`timescale 1ns/100ps

module execute (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  core_pkg::ex_t   up,
    output core_pkg::word_t bypass,
    output logic            load,
    output logic            branch,
    output core_pkg::word_t target,
    output core_pkg::mm_t   down
);
    import core_pkg::*;

    word_t result;

    always_comb begin
        case (up.op)
            OP_ADD, OP_ADDI,
            OP_LW, OP_SW: result = up.opa + up.opb; // Sum or data address
            OP_SUB:       result = up.opa - up.opb;
            OP_AND:       result = up.opa & up.opb;
            OP_OR:        result = up.opa | up.opb;
            OP_XOR:       result = up.opa ^ up.opb;
            default:      result = '0;
        endcase
    end

    assign bypass = result;                         // Forwarded to decode
    assign load   = up.valid && up.op == OP_LW;

    // BEQ compares rs1 against the rd-field register
    assign branch = up.valid && up.op == OP_BEQ && up.opa == up.sdata;
    assign target = up.pc + up.opb;                 // Word offset from the BEQ

    always_ff @(posedge clk) begin
        if (reset) begin
            down.valid <= 1'b0;
        end else if (!stall) begin                  // Frozen only by the output port
            down.valid  <= up.valid && !flush;      // Taken BEQ retires here
            down.op     <= up.op;
            down.rd     <= up.rd;
            down.rd_en  <= up.rd_en;
            down.result <= result;
            down.sdata  <= up.sdata;
        end
    end

endmodule

//--- source/fetch.sv
// Fetch stage with program counter, branch redirect and id output register
`timescale 1ns/100ps

module fetch #(
    parameter int CODE_AW = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 branch,
    input  core_pkg::word_t      target,
    output logic [CODE_AW-1:0]   code_addr,
    input  core_pkg::word_t      code_data,
    output core_pkg::id_t        down
);
    import core_pkg::*;

    word_t pc;                                      // Word index into code memory

    assign code_addr = pc[CODE_AW-1:0];             // Combinational read, same cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (branch && !stall) begin        // Taken BEQ from execute
            pc <= target;
        end else if (!stall) begin
            pc <= pc + 1;
        end
    end

    // Fetched word and its pc go to decode
    always_ff @(posedge clk) begin
        if (reset) begin
            down.valid <= 1'b0;
        end else if (flush) begin
            down.valid <= 1'b0;                     // Younger slot killed
        end else if (!stall) begin
            down.valid <= 1'b1;
            down.pc    <= pc;
            down.inst  <= inst_t'(code_data);
        end
    end

endmodule

//--- source/hazard.sv
// Hazard unit with load-use and output stalls, branch flush and forwarding selects
`timescale 1ns/100ps

module hazard (
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                uses_rs2,
    input  core_pkg::reg_addr_t ex_rd,
    input  logic                ex_rd_en,
    input  logic                ex_load,
    input  core_pkg::reg_addr_t mm_rd,
    input  logic                mm_rd_en,
    input  logic                out_busy,
    input  logic                branch,
    output logic                stall,
    output logic                flush,
    output core_pkg::fwd_t      rs1_sel,
    output core_pkg::fwd_t      rs2_sel
);
    import core_pkg::*;

    logic rs1_ex;                                   // Source matches a producer
    logic rs1_mm;
    logic rs2_ex;
    logic rs2_mm;
    logic load_use;

    // rs1 arrives as r0 from decode when unused or invalid
    assign rs1_ex = ex_rd_en && rs1 != '0 && rs1 == ex_rd;
    assign rs1_mm = mm_rd_en && rs1 != '0 && rs1 == mm_rd;
    assign rs2_ex = uses_rs2 && ex_rd_en && rs2 != '0 && rs2 == ex_rd;
    assign rs2_mm = uses_rs2 && mm_rd_en && rs2 != '0 && rs2 == mm_rd;

    // Execute is newer than memory, so it wins
    assign rs1_sel = rs1_ex ? FWD_EX : (rs1_mm ? FWD_MM : FWD_RF);
    assign rs2_sel = rs2_ex ? FWD_EX : (rs2_mm ? FWD_MM : FWD_RF);

    // Load data only exists once the load reaches memory
    assign load_use = ex_load && (rs1_ex || rs2_ex);

    assign stall = load_use || out_busy;

    // BEQ and load share the ex slot, so only out_busy can delay a redirect
    assign flush = branch && !out_busy;

endmodule

//--- source/memory.sv
// Memory stage with data RAM, OUT credit counter and writeback register
`timescale 1ns/100ps

module memory #(
    parameter int DATA_AW     = 6,
    parameter int OUT_CREDITS = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::mm_t   up,
    output core_pkg::word_t bypass,
    output logic            out_busy,
    output logic            out_valid,
    output core_pkg::word_t out_data,
    input  logic            out_credit,
    output core_pkg::wb_t   down
);
    import core_pkg::*;

    localparam int CW = $clog2(OUT_CREDITS + 1);    // Counter holds 0 to OUT_CREDITS

    word_t              ram [1 << DATA_AW];         // Local data RAM
    logic [DATA_AW-1:0] addr;
    logic [CW-1:0]      credits;                    // Free slots at the receiver
    logic               is_out;
    logic               is_load;
    logic               is_store;

    assign addr     = up.result[DATA_AW-1:0];       // Low word address bits
    assign is_out   = up.valid && up.op == OP_OUT;
    assign is_load  = up.valid && up.op == OP_LW;
    assign is_store = up.valid && up.op == OP_SW;

    always_ff @(posedge clk) begin
        if (is_store) begin
            ram[addr] <= up.sdata;
        end
    end

    assign bypass = is_load ? ram[addr] : up.result;   // Load data or ALU value

    // OUT needs a credit, otherwise the whole pipe waits
    assign out_valid = is_out && credits != '0;
    assign out_busy  = is_out && credits == '0;
    assign out_data  = up.sdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CW'(OUT_CREDITS);            // Receiver starts empty
        end else begin
            credits <= credits + CW'(out_credit) - CW'(out_valid);
        end
    end

    // Held while busy; repeating the same write is harmless
    always_ff @(posedge clk) begin
        if (reset) begin
            down.valid <= 1'b0;
        end else if (!out_busy) begin
            down.valid <= up.valid;
            down.rd_en <= up.rd_en;
            down.rd    <= up.rd;
            down.data  <= bypass;
        end
    end

endmodule

//--- source/regfile.sv
// Register file, 16 x 32, two write-first read ports, register 0 reads zero
`timescale 1ns/100ps

module regfile (
    input  logic                clk,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                rd_en,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::word_t     rd_data
);
    import core_pkg::*;

    word_t regs [REG_N];                            // Architectural registers

    always_ff @(posedge clk) begin
        if (rd_en && rd_addr != '0) begin           // Writes to r0 dropped
            regs[rd_addr] <= rd_data;
        end
    end

    // Same-cycle write is visible to the reader
    assign rs1_data = (rs1_addr == '0)                      ? '0      :
                      (rd_en && rd_addr == rs1_addr)        ? rd_data :
                                                              regs[rs1_addr];

    assign rs2_data = (rs2_addr == '0)                      ? '0      :
                      (rd_en && rd_addr == rs2_addr)        ? rd_data :
                                                              regs[rs2_addr];

endmodule

//--- testbench/cpu_tb.sv
// Testbench for the cpu core with code ROM, credit sink, ISA reference model and checks
`timescale 1ns/100ps

module cpu_tb;
    import core_pkg::*;

    localparam int CODE_AW     = 8;
    localparam int DATA_AW     = 6;
    localparam int OUT_CREDITS = 4;
    localparam int TIMEOUT     = 5000;              // Cycles per wait
    localparam int EXP_AW      = 6;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic [CODE_AW-1:0] code_addr;
    word_t              code_data;
    logic               out_valid;
    word_t              out_data;
    logic               out_credit = 1'b0;

    word_t       rom [1 << CODE_AW];                // Code ROM model
    int          prog_len;
    word_t       exp_words [1 << EXP_AW];           // Reference OUT sequence
    int          exp_n = 0;
    int          got_n = 0;                         // OUT words accepted this run
    int          outstanding = 0;                   // Sent minus credits returned
    logic [31:0] rng = 32'h626d_0486;
    logic        slow_sink = 1'b0;                  // Long credit droughts
    logic        give;
    logic        reset_q = 1'b1;
    logic        reset_qq = 1'b1;
    int          mismatches = 0;                    // Checker failures
    int          failures = 0;                      // Timeouts
    int          tests = 0;
    int          failed = 0;

    cpu #(.CODE_AW(CODE_AW), .DATA_AW(DATA_AW), .OUT_CREDITS(OUT_CREDITS)) uut (
        .clk, .reset, .code_addr, .code_data,
        .out_valid, .out_data, .out_credit
    );

    always #10 clk = ~clk;                          // 20 ns period

    assign code_data = rom[code_addr];              // Same-cycle code read

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk) begin
        reset_q  <= reset;                          // Reset as the core saw it
        reset_qq <= reset_q;
    end

    // Sink hands back a credit at random while it holds words
    assign give = (outstanding + int'(out_valid)) > 0 &&
                  (slow_sink ? rng[5:0] == 6'd0 : rng[0]);

    always @(negedge clk) begin
        rng <= next_random(rng);
        if (reset_q || reset_qq) begin
            assert (!out_valid) else begin
                $display("Error at %0t: out_valid high during or right after reset", $time);
                mismatches++;
            end
        end
        assert (outstanding <= OUT_CREDITS) else begin
            $display("Error at %0t: %0d words outstanding, receiver holds only %0d",
                     $time, outstanding, OUT_CREDITS);
            mismatches++;
        end
        if (reset_q) begin
            got_n       <= 0;                       // Sequence restarts
            outstanding <= 0;
            out_credit  <= 1'b0;
        end else begin
            if (out_valid) begin
                assert (got_n < exp_n && out_data == exp_words[got_n[EXP_AW-1:0]]) else begin
                    if (got_n < exp_n) begin
                        $display("MISMATCH at %0t: OUT word %0d is %h, expected %h", $time,
                                 got_n, out_data, exp_words[got_n[EXP_AW-1:0]]);
                    end else begin
                        $display("Error at %0t: extra OUT word %h after %0d expected",
                                 $time, out_data, exp_n);
                    end
                    mismatches++;
                end
                got_n <= got_n + 1;
            end
            out_credit  <= give;
            outstanding <= outstanding + int'(out_valid) - int'(give);
        end
    end

    task automatic emit_r(input op_t op, input int rd, input int rs1, input int rs2);
        rom[prog_len[CODE_AW-1:0]] = {op, 4'(rd), 4'(rs1), 4'(rs2), 16'h0000};
        prog_len++;
    endtask

    task automatic emit_i(input op_t op, input int rd, input int rs1, input int imm);
        rom[prog_len[CODE_AW-1:0]] = {op, 4'(rd), 4'(rs1), 20'(imm)};
        prog_len++;
    endtask

    task automatic fill_rom();
        int a;
        for (a = 0; a < (1 << CODE_AW); a++) begin
            rom[a[CODE_AW-1:0]] = {4'hF, 20'h0, 8'(a)};  // Undefined op, address in low bits
        end
    endtask

    task automatic load_program(input int prog);
        fill_rom();
        prog_len = 0;
        case (prog)
            0: begin                                // ALU chains
                emit_i(OP_ADDI, 1, 0, 5);
                emit_i(OP_ADDI, 2, 1, 7);           // From execute
                emit_r(OP_ADD,  3, 1, 2);           // Memory and execute
                emit_r(OP_SUB,  4, 3, 1);
                emit_r(OP_XOR,  5, 4, 3);
                emit_i(OP_ADDI, 0, 0, 99);          // r0 stays zero
                emit_r(OP_OR,   6, 0, 5);
                emit_i(OP_OUT,  6, 0, 0);
                emit_i(OP_ADDI, 8, 0, -3);
                emit_r(OP_AND,  7, 6, 2);
                emit_i(OP_OUT,  0, 0, 0);
                emit_i(OP_OUT,  8, 0, 0);           // Write-first read
                emit_i(OP_OUT,  7, 0, 0);
                emit_i(OP_OUT,  4, 0, 0);
            end
            1: begin                                // Loads and stores
                emit_i(OP_ADDI, 1, 0, 10);
                emit_i(OP_ADDI, 2, 0, -7);
                emit_i(OP_SW,   1, 0, 3);
                emit_i(OP_SW,   2, 1, 40);
                emit_i(OP_LW,   3, 0, 3);
                emit_r(OP_ADD,  4, 3, 3);           // Load-use
                emit_i(OP_LW,   5, 1, 40);
                emit_i(OP_OUT,  5, 0, 0);           // Load-use into OUT
                emit_i(OP_SW,   5, 2, 20);          // Negative base
                emit_i(OP_LW,   6, 2, 20);
                emit_i(OP_SW,   6, 0, 60);          // Load-use into store data
                emit_i(OP_LW,   7, 0, 60);
                emit_i(OP_OUT,  4, 0, 0);
                emit_i(OP_OUT,  7, 0, 0);
            end
            2: begin                                // Branches over OUTs
                emit_i(OP_ADDI, 1, 0, 3);
                emit_i(OP_ADDI, 2, 0, 0);
                emit_i(OP_BEQ,  1, 1, 3);           // Taken
                emit_i(OP_OUT,  1, 0, 0);           // Flushed
                emit_i(OP_OUT,  1, 0, 0);           // Flushed
                emit_i(OP_ADDI, 2, 2, 1);
                emit_i(OP_OUT,  2, 0, 0);
                emit_i(OP_BEQ,  1, 2, 3);           // Exit when r2 == 3
                emit_i(OP_BEQ,  0, 0, -3);          // Back to the increment
                emit_i(OP_OUT,  1, 0, 0);           // Always flushed
                emit_i(OP_OUT,  2, 0, 0);
            end
            default: begin                          // OUT stream
                emit_i(OP_ADDI, 1, 0, 1);
                emit_i(OP_ADDI, 3, 0, 10);
                emit_i(OP_OUT,  1, 0, 0);
                emit_r(OP_ADD,  1, 1, 1);
                emit_i(OP_ADDI, 3, 3, -1);
                emit_i(OP_BEQ,  0, 3, 2);
                emit_i(OP_BEQ,  0, 0, -4);
                emit_i(OP_OUT,  1, 0, 0);
                emit_i(OP_OUT,  3, 0, 0);
                emit_i(OP_OUT,  1, 0, 0);
            end
        endcase
        emit_i(OP_BEQ, 0, 0, 0);                    // Halt loop
    endtask

    // Instruction set interpreter over the ROM contents
    task automatic build_expected();
        word_t regs [16];
        word_t dmem [1 << DATA_AW];
        word_t pc;
        word_t next_pc;
        word_t w;
        word_t src1;
        word_t src2;
        word_t imm;
        word_t addr;
        int    steps;
        logic  halted;
        regs   = '{default: '0};
        dmem   = '{default: '0};
        pc     = '0;
        exp_n  = 0;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < 1000) begin
            w       = rom[pc[CODE_AW-1:0]];
            src1    = regs[w[23:20]];
            src2    = regs[w[27:24]];               // rd field as a source
            imm     = {{12{w[19]}}, w[19:0]};
            addr    = src1 + imm;
            next_pc = pc + 1;
            case (w[31:28])
                OP_ADD:  regs[w[27:24]] = src1 + regs[w[19:16]];
                OP_SUB:  regs[w[27:24]] = src1 - regs[w[19:16]];
                OP_AND:  regs[w[27:24]] = src1 & regs[w[19:16]];
                OP_OR:   regs[w[27:24]] = src1 | regs[w[19:16]];
                OP_XOR:  regs[w[27:24]] = src1 ^ regs[w[19:16]];
                OP_ADDI: regs[w[27:24]] = addr;
                OP_LW:   regs[w[27:24]] = dmem[addr[DATA_AW-1:0]];
                OP_SW:   dmem[addr[DATA_AW-1:0]] = src2;
                OP_BEQ: begin
                    if (src1 == src2) begin
                        next_pc = pc + imm;
                        halted  = (imm == '0);
                    end
                end
                OP_OUT: begin
                    if (exp_n < (1 << EXP_AW)) begin
                        exp_words[exp_n[EXP_AW-1:0]] = src2;
                        exp_n++;
                    end
                end
                default: begin
                end
            endcase
            regs[4'd0] = '0;
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic wait_words(input int n);
        int t;
        t = 0;
        while (got_n < n && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (got_n < n) begin
            $display("Timeout at %0t: only %0d of %0d OUT words arrived", $time, got_n, n);
            failures++;
        end
    endtask

    task automatic run_program(input string name, input int prog, input logic slow,
                               input int reset_at);
        int   errors_before;
        logic ok;
        errors_before = mismatches + failures;
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        slow_sink = slow;
        load_program(prog);                         // Core held in reset meanwhile
        build_expected();
        @(negedge clk);
        reset = 1'b0;
        if (reset_at > 0) begin
            wait_words(reset_at);
            @(negedge clk);
            reset = 1'b1;                           // Reset in the middle of the run
            repeat (2) @(negedge clk);
            reset = 1'b0;
        end
        wait_words(exp_n);
        repeat (20) @(posedge clk);                 // Late extra words would show here
        ok = (mismatches + failures == errors_before);
        tests++;
        if (!ok) begin
            failed++;
        end
        $display("test %0d %s: %s, %0d of %0d words", tests, name, ok ? "ok" : "FAIL",
                 got_n, exp_n);
    endtask

    initial begin
        fill_rom();                                 // Defined code word from time zero
        run_program("alu forwarding", 0, 1'b0, 0);
        run_program("load store", 1, 1'b0, 0);
        run_program("branch flush", 2, 1'b0, 0);
        run_program("credit back-pressure", 3, 1'b1, 0);
        run_program("reset mid program", 0, 1'b0, 3);
        $display("%0d tests, %0d failed, %0d errors", tests, failed, mismatches + failures);
        if (failed == 0 && mismatches + failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
